//--- project.f
+incdir+common
common/qbert_game_pkg.sv
common/qbert_video_pkg.sv
hw/pyramid/cube_cell.sv
hw/frame_control.sv
hw/pixel_colorizer.sv
hw/qbert_map.sv
verif/qbert_map_props.sv
verif/tb_qbert_map.sv

//--- Makefile
# Verilator flow for the qbert playfield map testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module tb_qbert_map

sim:
	verilator --binary --timing --assert -f project.f --top-module tb_qbert_map \
		-Mdir obj_dir -o sim_qbert
	./obj_dir/sim_qbert +verilator+error+limit+1000 2>&1 | tee sim.log
	@if grep -q "Test passed" sim.log; then \
		echo "simulation ok"; \
	else \
		echo "simulation reported failure, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_qbert_map.sv
// testbench for the qbert playfield map
// drives modes, raster sweeps, pause and qbert moves into the bound checks

`default_nettype none
`timescale 1ns/1ps

`include "qbert_cfg.svh"

module tb_qbert_map;

	localparam int HX = `QB_HALF_X;
	localparam int HY = `QB_HALF_Y;
	localparam int PIX_BURST = 6;
	localparam int N_SWEEP = 11;
	localparam int N_RAND = 160;
	localparam int N_OFF = 4;
	// reset, mode, tops, visited, pause, position, drain
	localparam int SCRIPT_CYCLES = 5 + 7 * PIX_BURST + 8 + `QB_N_CUBE * N_SWEEP + N_RAND +
		2 + PIX_BURST + 2 * `QB_N_CUBE + (3 * `QB_N_CUBE + N_OFF) * 4 + 4;
	localparam int WATCHDOG_CYCLES = SCRIPT_CYCLES + 100;

	typedef logic [`QB_N_CUBE-1:0] cube_mask_t;

	logic CLK_33;
	logic rst_n;
	qbert_game_pkg::x_t x_cnt;
	qbert_game_pkg::y_t y_cnt;
	qbert_game_pkg::x_t qbert_x;
	qbert_game_pkg::y_t qbert_y;
	logic move_done;
	logic start;
	logic pause;
	logic resume;
	logic menu;
	logic gameover;
	cube_mask_t color_state;
	qbert_video_pkg::rgb_t pixel_rgb;
	cube_mask_t position_qb;
	qbert_game_pkg::screen_mode_e mode;

	integer seed;
	int err_total;

	// raster offsets from a cube anchor on the edges and just outside
	int sweep_dx [N_SWEEP] = '{0, 0, 0, -HX, HX, -HX - 1, HX + 1, 0, 0, -HX, HX};
	int sweep_dy [N_SWEEP] = '{0, HY, 2 * HY, HY, HY, HY, HY, -1, 2 * HY + 1, 0, 2 * HY};
	// qbert spots off the pyramid
	int off_x [N_OFF] = '{0, 100, 600, 250};
	int off_y [N_OFF] = '{0, 400, 50, 100};

	qbert_map u_qbert_map (.*);

	bind qbert_map qbert_map_props u_props (.*);

	always #2 CLK_33 = ~CLK_33;

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge CLK_33);
		#0.5;
	endtask

	function automatic int rand_below(input int n);
		rand_below = int'($unsigned($random(seed)) % n);
	endfunction

	function automatic int anchor_x(input int r);
		anchor_x = `QB_R1_X + r * `QB_RANK_DX;
	endfunction

	function automatic int anchor_y(input int r, input int c);
		anchor_y = `QB_R1_Y + r * `QB_RANK_DY - c * `QB_COL_DY;
	endfunction

	task automatic show_pixel(input int x, input int y);
		x_cnt = qbert_game_pkg::x_t'(x);
		y_cnt = qbert_game_pkg::y_t'(y);
		next_cycle();
	endtask

	task automatic random_pixels(input int n);
		repeat (n) show_pixel(rand_below(640), rand_below(480));
	endtask

	// one-cycle control strobes
	task automatic pulse_controls(input logic s_start, input logic s_pause,
		input logic s_resume, input logic s_menu, input logic s_gameover);
		start = s_start;
		pause = s_pause;
		resume = s_resume;
		menu = s_menu;
		gameover = s_gameover;
		next_cycle();
		start = 1'b0;
		pause = 1'b0;
		resume = 1'b0;
		menu = 1'b0;
		gameover = 1'b0;
	endtask

	// move with strobe then noise on the position bus
	task automatic place_qbert(input int x, input int y);
		qbert_x = qbert_game_pkg::x_t'(x);
		qbert_y = qbert_game_pkg::y_t'(y);
		move_done = 1'b1;
		next_cycle();
		move_done = 1'b0;
		repeat (3) begin
			qbert_x = qbert_game_pkg::x_t'(rand_below(640));
			qbert_y = qbert_game_pkg::y_t'(rand_below(480));
			next_cycle();
		end
	endtask

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	initial begin
		int r;
		int c;
		int k;
		seed = 55997;
		CLK_33 = 1'b0;
		rst_n = 1'b1;
		x_cnt = '0;
		y_cnt = '0;
		qbert_x = '0;
		qbert_y = '0;
		move_done = 1'b0;
		start = 1'b0;
		pause = 1'b0;
		resume = 1'b0;
		menu = 1'b0;
		gameover = 1'b0;
		color_state = '0;
		#0.5;
		rst_n = 1'b0;
		repeat (3) next_cycle();
		rst_n = 1'b1;
		repeat (2) next_cycle();

		// mode walk with flat screens in menu and over
		random_pixels(PIX_BURST);
		pulse_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		random_pixels(PIX_BURST);
		pulse_controls(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
		random_pixels(PIX_BURST);
		pulse_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		random_pixels(PIX_BURST);
		pulse_controls(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
		random_pixels(PIX_BURST);
		// pause also leaves the menu
		pulse_controls(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		pulse_controls(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
		random_pixels(PIX_BURST);
		pulse_controls(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
		random_pixels(PIX_BURST);
		pulse_controls(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);

		// cube tops and their borders
		color_state = '0;
		for (r = 0; r < `QB_N_RANK; r++)
			for (c = 0; c <= r; c++)
				for (k = 0; k < N_SWEEP; k++)
					show_pixel(anchor_x(r) + sweep_dx[k], anchor_y(r, c) + sweep_dy[k]);

		// visited bits from random words at points near a random cube
		for (k = 0; k < N_RAND; k++) begin
			r = rand_below(`QB_N_RANK);
			c = rand_below(r + 1);
			color_state = cube_mask_t'($random(seed));
			show_pixel(anchor_x(r) + rand_below(2 * HX + 7) - HX - 3,
				anchor_y(r, c) + rand_below(2 * HY + 1));
		end

		// paused palette and back
		pulse_controls(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		// mostly background in the dimmed palette
		random_pixels(PIX_BURST);
		for (r = 0; r < `QB_N_RANK; r++)
			for (c = 0; c <= r; c++) begin
				color_state = cube_mask_t'($random(seed));
				show_pixel(anchor_x(r), anchor_y(r, c) + HY);
			end
		pulse_controls(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		for (r = 0; r < `QB_N_RANK; r++)
			for (c = 0; c <= r; c++) begin
				color_state = cube_mask_t'($random(seed));
				show_pixel(anchor_x(r), anchor_y(r, c) + HY);
			end

		// qbert on centres, inner corners and just off each cube
		for (r = 0; r < `QB_N_RANK; r++)
			for (c = 0; c <= r; c++) begin
				place_qbert(anchor_x(r), anchor_y(r, c) + HY);
				place_qbert(anchor_x(r) + HX / 2, anchor_y(r, c) + HY - HY / 2);
				place_qbert(anchor_x(r) - HX / 2 - 1, anchor_y(r, c) + HY);
			end
		for (k = 0; k < N_OFF; k++)
			place_qbert(off_x[k], off_y[k]);

		// drain the pixel pipeline
		repeat (4) next_cycle();

		err_total = u_qbert_map.u_props.reset_errs + u_qbert_map.u_props.mode_errs +
			u_qbert_map.u_props.pixel_errs + u_qbert_map.u_props.pos_errs;
		$display("Errors: reset %0d, mode %0d, pixel %0d, position %0d, total %0d",
			u_qbert_map.u_props.reset_errs, u_qbert_map.u_props.mode_errs,
			u_qbert_map.u_props.pixel_errs, u_qbert_map.u_props.pos_errs, err_total);
		if (err_total == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_33);
		$display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/qbert_map_props.sv
// assertion set for the qbert playfield map
// reference model of mode, pause and position with pixel and position checks

`default_nettype none
`timescale 1ns/1ps

`include "qbert_cfg.svh"

module qbert_map_props (
	input  logic                          CLK_33,
	input  logic                          rst_n,
	input  qbert_game_pkg::x_t            x_cnt,
	input  qbert_game_pkg::y_t            y_cnt,
	input  qbert_game_pkg::x_t            qbert_x,
	input  qbert_game_pkg::y_t            qbert_y,
	input  logic                          move_done,
	input  logic                          start,
	input  logic                          pause,
	input  logic                          resume,
	input  logic                          menu,
	input  logic                          gameover,
	input  logic [`QB_N_CUBE-1:0]         color_state,
	input  qbert_video_pkg::rgb_t         pixel_rgb,
	input  logic [`QB_N_CUBE-1:0]         position_qb,
	input  qbert_game_pkg::screen_mode_e  mode
);

	// failure counts, read by the testbench at the end
	int reset_errs = 0;
	int mode_errs = 0;
	int pixel_errs = 0;
	int pos_errs = 0;

	qbert_game_pkg::screen_mode_e exp_mode;
	qbert_game_pkg::screen_mode_e next_mode;
	logic exp_paused;
	qbert_game_pkg::x_t exp_qb_x;
	qbert_game_pkg::y_t exp_qb_y;
	// edges seen since reset release, saturates at pipeline depth
	logic [1:0] live_cnt;

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------
	always_comb begin
		next_mode = exp_mode;
		if (exp_mode == qbert_game_pkg::MODE_MENU && (start || pause))
			next_mode = qbert_game_pkg::MODE_PLAY;
		else if (exp_mode == qbert_game_pkg::MODE_PLAY && menu)
			next_mode = qbert_game_pkg::MODE_MENU;
		else if (exp_mode == qbert_game_pkg::MODE_PLAY && gameover)
			next_mode = qbert_game_pkg::MODE_OVER;
		else if (exp_mode == qbert_game_pkg::MODE_OVER && menu)
			next_mode = qbert_game_pkg::MODE_MENU;
		else if (exp_mode == qbert_game_pkg::MODE_OVER && start)
			next_mode = qbert_game_pkg::MODE_PLAY;
	end

	always_ff @(posedge CLK_33 or negedge rst_n) begin
		if (!rst_n) begin
			exp_mode   <= qbert_game_pkg::MODE_MENU;
			exp_paused <= 1'b0;
			exp_qb_x   <= '0;
			exp_qb_y   <= '0;
			live_cnt   <= 2'd0;
		end else begin
			exp_mode <= next_mode;
			// leaving play, resume or start all clear the pause
			if (next_mode != qbert_game_pkg::MODE_PLAY || resume || start)
				exp_paused <= 1'b0;
			else if (pause && exp_mode == qbert_game_pkg::MODE_PLAY)
				exp_paused <= 1'b1;
			if (move_done) begin
				exp_qb_x <= qbert_x;
				exp_qb_y <= qbert_y;
			end
			if (live_cnt != 2'd3)
				live_cnt <= live_cnt + 2'd1;
		end
	end

	// colour of one raster point
	function automatic qbert_video_pkg::rgb_t expect_rgb(
		input qbert_game_pkg::x_t            px,
		input qbert_game_pkg::y_t            py,
		input logic [`QB_N_CUBE-1:0]         cs,
		input qbert_game_pkg::screen_mode_e  m,
		input logic                          p
	);
		logic [`QB_N_CUBE-1:0] hits;
		int r;
		int c;
		int ax;
		int ay;
		hits = '0;
		for (r = 0; r < `QB_N_RANK; r++) begin
			for (c = 0; c <= r; c++) begin
				ax = `QB_R1_X + r * `QB_RANK_DX;
				ay = `QB_R1_Y + r * `QB_RANK_DY - c * `QB_COL_DY;
				hits[r * (r + 1) / 2 + c] = (int'(px) - ax <= `QB_HALF_X) &&
					(ax - int'(px) <= `QB_HALF_X) && (int'(py) >= ay) &&
					(int'(py) - ay <= 2 * `QB_HALF_Y);
			end
		end
		if (m == qbert_game_pkg::MODE_MENU)
			expect_rgb = `QB_RGB_MENU;
		else if (m == qbert_game_pkg::MODE_OVER)
			expect_rgb = `QB_RGB_OVER;
		else if (hits == '0)
			expect_rgb = p ? `QB_RGB_P_BG : `QB_RGB_BG;
		else if ((hits & cs) != '0)
			expect_rgb = p ? `QB_RGB_P_VISITED : `QB_RGB_VISITED;
		else
			expect_rgb = p ? `QB_RGB_P_TOP : `QB_RGB_TOP;
	endfunction

	// one-hot cube under qbert, zero off the pyramid
	function automatic logic [`QB_N_CUBE-1:0] expect_position(
		input qbert_game_pkg::x_t qx,
		input qbert_game_pkg::y_t qy
	);
		int r;
		int c;
		int dx;
		int dy;
		expect_position = '0;
		for (r = 0; r < `QB_N_RANK; r++) begin
			for (c = 0; c <= r; c++) begin
				dx = int'(qx) - (`QB_R1_X + r * `QB_RANK_DX);
				dy = int'(qy) - (`QB_R1_Y + r * `QB_RANK_DY - c * `QB_COL_DY + `QB_HALF_Y);
				if (dx <= `QB_HALF_X / 2 && -dx <= `QB_HALF_X / 2 &&
					dy <= `QB_HALF_Y / 2 && -dy <= `QB_HALF_Y / 2)
					expect_position[r * (r + 1) / 2 + c] = 1'b1;
			end
		end
	endfunction

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	a_reset_state: assert property (@(posedge CLK_33)
		(!rst_n || $rose(rst_n)) |->
		(mode == qbert_game_pkg::MODE_MENU && position_qb == '0 && pixel_rgb == '0))
		else begin
			reset_errs = reset_errs + 1;
			$error("Error at %0t: outputs are not at their reset values", $time);
		end

	a_mode: assert property (@(posedge CLK_33) disable iff (!rst_n)
		mode == exp_mode)
		else begin
			mode_errs = mode_errs + 1;
			$error("Error at %0t: mode %0d, expected %0d", $time, mode, exp_mode);
		end

	// pixel three edges after its raster point
	a_pixel: assert property (@(posedge CLK_33) disable iff (!rst_n)
		(live_cnt == 2'd3) |-> pixel_rgb == expect_rgb($past(x_cnt, 3), $past(y_cnt, 3),
		$past(color_state), $past(exp_mode), $past(exp_paused)))
		else begin
			pixel_errs = pixel_errs + 1;
			$error("Error at %0t: pixel_rgb %h differs from the expected colour",
				$time, pixel_rgb);
		end

	a_position: assert property (@(posedge CLK_33) disable iff (!rst_n)
		position_qb == expect_position($past(exp_qb_x), $past(exp_qb_y)))
		else begin
			pos_errs = pos_errs + 1;
			$error("Error at %0t: position_qb %h is wrong", $time, position_qb);
		end

	a_position_hold: assert property (@(posedge CLK_33) disable iff (!rst_n)
		!$past(move_done, 2) |-> $stable(position_qb))
		else begin
			pos_errs = pos_errs + 1;
			$error("Error at %0t: position_qb moved without move_done", $time);
		end

endmodule

`default_nettype wire

//--- hw/qbert_map.sv
// qbert playfield map, top level
// mode controller, 28 cube cells and the pixel colouriser

`default_nettype none
`timescale 1ns/1ps

`include "qbert_cfg.svh"

module qbert_map (
	input  logic                          CLK_33,
	input  logic                          rst_n,
	input  qbert_game_pkg::x_t            x_cnt,
	input  qbert_game_pkg::y_t            y_cnt,
	input  qbert_game_pkg::x_t            qbert_x,
	input  qbert_game_pkg::y_t            qbert_y,
	input  logic                          move_done,
	input  logic                          start,
	input  logic                          pause,
	input  logic                          resume,
	input  logic                          menu,
	input  logic                          gameover,
	input  logic [`QB_N_CUBE-1:0]         color_state,
	output qbert_video_pkg::rgb_t         pixel_rgb,
	output logic [`QB_N_CUBE-1:0]         position_qb,
	output qbert_game_pkg::screen_mode_e  mode
);

	// registered raster and latched qbert position
	qbert_game_pkg::x_t pix_x;
	qbert_game_pkg::y_t pix_y;
	qbert_game_pkg::x_t qb_x;
	qbert_game_pkg::y_t qb_y;
	logic paused;
	// one top hit per cube, pipeline stage 2
	logic [`QB_N_CUBE-1:0] top_hit;

	// ------------------------------------------------------------------
	// mode fsm, raster stage 1, position latch
	// ------------------------------------------------------------------
	frame_control u_frame_control (
		.CLK_33   (CLK_33),
		.rst_n    (rst_n),
		.x_cnt    (x_cnt),
		.y_cnt    (y_cnt),
		.qbert_x  (qbert_x),
		.qbert_y  (qbert_y),
		.move_done(move_done),
		.start    (start),
		.pause    (pause),
		.resume   (resume),
		.menu     (menu),
		.gameover (gameover),
		.pix_x    (pix_x),
		.pix_y    (pix_y),
		.qb_x     (qb_x),
		.qb_y     (qb_y),
		.mode     (mode),
		.paused   (paused)
	);

	// ------------------------------------------------------------------
	// pyramid, rank r holds r+1 cubes
	// ------------------------------------------------------------------
	for (genvar r = 0; r < `QB_N_RANK; r++) begin : g_rank
		for (genvar c = 0; c <= r; c++) begin : g_col
			// flat index, ranks packed one after another
			localparam int IDX = r * (r + 1) / 2 + c;

			cube_cell #(
				.RANK(r),
				.COL (c)
			) u_cube_cell (
				.CLK_33 (CLK_33),
				.rst_n  (rst_n),
				.pix_x  (pix_x),
				.pix_y  (pix_y),
				.qb_x   (qb_x),
				.qb_y   (qb_y),
				.top_hit(top_hit[IDX]),
				.on_cube(position_qb[IDX])
			);
		end
	end

	// stage 3, one rgb per pixel
	pixel_colorizer u_pixel_colorizer (
		.CLK_33     (CLK_33),
		.rst_n      (rst_n),
		.top_hit    (top_hit),
		.color_state(color_state),
		.mode       (mode),
		.paused     (paused),
		.pixel_rgb  (pixel_rgb)
	);

endmodule

`default_nettype wire

//--- hw/pixel_colorizer.sv
// pixel colouriser of the qbert playfield
// reduces the cube hits to one rgb pixel per screen mode and palette

`default_nettype none
`timescale 1ns/1ps

`include "qbert_cfg.svh"

module pixel_colorizer (
	input  logic                          CLK_33,
	input  logic                          rst_n,
	input  logic [`QB_N_CUBE-1:0]         top_hit,
	input  logic [`QB_N_CUBE-1:0]         color_state,
	input  qbert_game_pkg::screen_mode_e  mode,
	input  logic                          paused,
	output qbert_video_pkg::rgb_t         pixel_rgb
);

	qbert_video_pkg::tile_kind_e tile_kind;
	qbert_video_pkg::rgb_t tile_rgb;
	qbert_video_pkg::rgb_t rgb_nxt;

	// ------------------------------------------------------------------
	// tile classification
	// ------------------------------------------------------------------
	always_comb begin
		if (|top_hit) begin
			// visited when a hit cube has its bit set
			if (|(top_hit & color_state))
				tile_kind = qbert_video_pkg::TILE_VISITED;
			else
				tile_kind = qbert_video_pkg::TILE_TOP;
		end else begin
			tile_kind = qbert_video_pkg::TILE_NONE;
		end
	end

	// ------------------------------------------------------------------
	// palette lookup
	// ------------------------------------------------------------------
	always_comb begin
		if (paused) begin
			// dimmed palette
			case (tile_kind)
				qbert_video_pkg::TILE_TOP:     tile_rgb = `QB_RGB_P_TOP;
				qbert_video_pkg::TILE_VISITED: tile_rgb = `QB_RGB_P_VISITED;
				default:                       tile_rgb = `QB_RGB_P_BG;
			endcase
		end else begin
			case (tile_kind)
				qbert_video_pkg::TILE_TOP:     tile_rgb = `QB_RGB_TOP;
				qbert_video_pkg::TILE_VISITED: tile_rgb = `QB_RGB_VISITED;
				default:                       tile_rgb = `QB_RGB_BG;
			endcase
		end
	end

	// screen mode picks the source
	always_comb begin
		case (mode)
			qbert_game_pkg::MODE_PLAY: rgb_nxt = tile_rgb;
			qbert_game_pkg::MODE_OVER: rgb_nxt = `QB_RGB_OVER;
			// menu screen is one flat colour
			default:                   rgb_nxt = `QB_RGB_MENU;
		endcase
	end

	// ------------------------------------------------------------------
	// raster stage 3
	// ------------------------------------------------------------------
	always_ff @(posedge CLK_33 or negedge rst_n) begin
		if (!rst_n)
			pixel_rgb <= '0;
		else
			pixel_rgb <= rgb_nxt;
	end

endmodule

`default_nettype wire

//--- hw/frame_control.sv
// frame controller of the qbert playfield
// screen mode fsm, pause flag, raster register and qbert position latch

`default_nettype none
`timescale 1ns/1ps

module frame_control (
	input  logic                          CLK_33,
	input  logic                          rst_n,
	input  qbert_game_pkg::x_t            x_cnt,
	input  qbert_game_pkg::y_t            y_cnt,
	input  qbert_game_pkg::x_t            qbert_x,
	input  qbert_game_pkg::y_t            qbert_y,
	input  logic                          move_done,
	input  logic                          start,
	input  logic                          pause,
	input  logic                          resume,
	input  logic                          menu,
	input  logic                          gameover,
	output qbert_game_pkg::x_t            pix_x,
	output qbert_game_pkg::y_t            pix_y,
	output qbert_game_pkg::x_t            qb_x,
	output qbert_game_pkg::y_t            qb_y,
	output qbert_game_pkg::screen_mode_e  mode,
	output logic                          paused
);

	qbert_game_pkg::screen_mode_e mode_nxt;
	logic paused_nxt;

	// ------------------------------------------------------------------
	// screen mode fsm
	// ------------------------------------------------------------------
	always_comb begin
		mode_nxt = mode;
		case (mode)
			qbert_game_pkg::MODE_MENU: begin
				// pause also leaves the menu
				if (start || pause)
					mode_nxt = qbert_game_pkg::MODE_PLAY;
			end
			qbert_game_pkg::MODE_PLAY: begin
				if (menu)
					mode_nxt = qbert_game_pkg::MODE_MENU;
				else if (gameover)
					mode_nxt = qbert_game_pkg::MODE_OVER;
			end
			qbert_game_pkg::MODE_OVER: begin
				if (menu)
					mode_nxt = qbert_game_pkg::MODE_MENU;
				else if (start)
					mode_nxt = qbert_game_pkg::MODE_PLAY;
			end
			default: mode_nxt = qbert_game_pkg::MODE_MENU;
		endcase
	end

	// pause flag only lives inside play
	always_comb begin
		paused_nxt = paused;
		if (mode_nxt != qbert_game_pkg::MODE_PLAY)
			paused_nxt = 1'b0;
		else if (resume || start)
			paused_nxt = 1'b0;
		else if (pause && mode == qbert_game_pkg::MODE_PLAY)
			paused_nxt = 1'b1;
	end

	always_ff @(posedge CLK_33 or negedge rst_n) begin
		if (!rst_n) begin
			mode   <= qbert_game_pkg::MODE_MENU;
			paused <= 1'b0;
			qb_x   <= '0;
			qb_y   <= '0;
		end else begin
			mode   <= mode_nxt;
			paused <= paused_nxt;
			// position holds between moves
			if (move_done) begin
				qb_x <= qbert_x;
				qb_y <= qbert_y;
			end
		end
	end

	// raster stage 1
	always_ff @(posedge CLK_33) begin
		pix_x <= x_cnt;
		pix_y <= y_cnt;
	end

endmodule

`default_nettype wire

//--- hw/pyramid/cube_cell.sv
// one cube of the pyramid
// top hitbox test on the raster and qbert-on-cube test

`default_nettype none
`timescale 1ns/1ps

`include "qbert_cfg.svh"

module cube_cell #(
	parameter int RANK = 0,
	parameter int COL  = 0
) (
	input  logic                CLK_33,
	input  logic                rst_n,
	input  qbert_game_pkg::x_t  pix_x,
	input  qbert_game_pkg::y_t  pix_y,
	input  qbert_game_pkg::x_t  qb_x,
	input  qbert_game_pkg::y_t  qb_y,
	output logic                top_hit,
	output logic                on_cube
);

	// anchor, apex of the cube top
	localparam int AX = `QB_R1_X + RANK * `QB_RANK_DX;
	localparam int AY = `QB_R1_Y + RANK * `QB_RANK_DY - COL * `QB_COL_DY;

	// top hitbox, full width and full height
	localparam int TOP_X_LO = AX - `QB_HALF_X;
	localparam int TOP_X_HI = AX + `QB_HALF_X;
	localparam int TOP_Y_LO = AY;
	localparam int TOP_Y_HI = AY + 2 * `QB_HALF_Y;

	// qbert box around the top centre, half size
	localparam int ON_Y_MID = AY + `QB_HALF_Y;
	localparam int ON_X_LO  = AX - `QB_HALF_X / 2;
	localparam int ON_X_HI  = AX + `QB_HALF_X / 2;
	localparam int ON_Y_LO  = ON_Y_MID - `QB_HALF_Y / 2;
	localparam int ON_Y_HI  = ON_Y_MID + `QB_HALF_Y / 2;

	logic top_in;
	logic qb_in;

	always_comb begin
		top_in = (int'(pix_x) >= TOP_X_LO) && (int'(pix_x) <= TOP_X_HI) &&
			(int'(pix_y) >= TOP_Y_LO) && (int'(pix_y) <= TOP_Y_HI);
		qb_in = (int'(qb_x) >= ON_X_LO) && (int'(qb_x) <= ON_X_HI) &&
			(int'(qb_y) >= ON_Y_LO) && (int'(qb_y) <= ON_Y_HI);
	end

	// raster stage 2
	always_ff @(posedge CLK_33) begin
		top_hit <= top_in;
	end

	// one edge after the position latch
	always_ff @(posedge CLK_33 or negedge rst_n) begin
		if (!rst_n)
			on_cube <= 1'b0;
		else
			on_cube <= qb_in;
	end

endmodule

`default_nettype wire

//--- common/qbert_video_pkg.sv
// video side types of the qbert playfield
// pixel colour and tile classification

`default_nettype none

package qbert_video_pkg;

	// one colour channel
	typedef logic [7:0] chan_t;

	// {r, g, b}, red in the top byte
	typedef chan_t [2:0] rgb_t;

	// what the current pixel belongs to
	typedef enum logic [1:0] {
		TILE_NONE    = 2'd0,
		TILE_TOP     = 2'd1,
		TILE_VISITED = 2'd2
	} tile_kind_e;

endpackage

`default_nettype wire

//--- common/qbert_game_pkg.sv
// game side types of the qbert playfield
// screen modes and raster coordinates

`default_nettype none

`include "qbert_cfg.svh"

package qbert_game_pkg;

	// raster coordinates, also used for the qbert position
	typedef logic [`QB_X_W-1:0] x_t;
	typedef logic [`QB_Y_W-1:0] y_t;

	// screen mode of the controller
	typedef enum logic [1:0] {
		MODE_MENU = 2'd0,
		MODE_PLAY = 2'd1,
		MODE_OVER = 2'd2
	} screen_mode_e;

endpackage

`default_nettype wire

//--- common/qbert_cfg.svh
// qbert playfield configuration
// raster geometry, pyramid layout and the colour palette

`ifndef QBERT_CFG_SVH
`define QBERT_CFG_SVH

// ----------------------------------------------------------------------
// raster and pyramid geometry
// ----------------------------------------------------------------------
// raster coordinate widths
`define QB_X_W 11
`define QB_Y_W 10

// seven ranks, 1+2+...+7 cubes
`define QB_N_RANK 7
`define QB_N_CUBE 28

// apex anchor of the top cube
`define QB_R1_X 250
`define QB_R1_Y 190
// anchor step from one rank to the next
`define QB_RANK_DX 37
`define QB_RANK_DY 22
// anchor step between columns of one rank
`define QB_COL_DY 44
// half diagonals of a cube top
`define QB_HALF_X 15
`define QB_HALF_Y 22

// ----------------------------------------------------------------------
// palette, {r, g, b}
// ----------------------------------------------------------------------
`define QB_RGB_TOP       {8'd222, 8'd222, 8'd0}
`define QB_RGB_VISITED   {8'd86, 8'd70, 8'd239}
`define QB_RGB_BG        {8'd0, 8'd0, 8'd0}
// dimmed set while the game is paused
`define QB_RGB_P_TOP     {8'd160, 8'd160, 8'd0}
`define QB_RGB_P_VISITED {8'd60, 8'd50, 8'd170}
`define QB_RGB_P_BG      {8'd50, 8'd50, 8'd50}
// flat screens
`define QB_RGB_MENU      {8'd0, 8'd0, 8'd80}
`define QB_RGB_OVER      {8'd0, 8'd50, 8'd100}

`endif
